//--- logic/mipsPkg.sv
/*
  mipsPkg
  widths, instruction encodings, ALU operations and the
  decoded control bundle shared by the single-cycle MIPS core
*/
package mipsPkg;

  // ========================================
  // widths
  // ========================================
  // data path and byte address
  localparam int dataWidth    = 32;
  // register index
  localparam int regAddrWidth = 5;
  // data SRAM word address, 128 words
  localparam int memAddrWidth = 7;

  // ========================================
  // opcodes, instr[31:26]
  // ========================================
  localparam logic [5:0] opRtype = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  // ========================================
  // function codes, instr[5:0] of R-type
  // ========================================
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // jal return address lands here
  localparam logic [regAddrWidth-1:0] linkReg = regAddrWidth'(31);

  // ========================================
  // ALU operation select
  // ========================================
  // aluNone drives a zero result
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOpT;

  // ========================================
  // decoded control, one per instruction
  // ========================================
  typedef struct packed {
    // write index from rd, else rt
    logic  regDst;
    // operand B is the sign-extended immediate
    logic  aluSrc;
    // write-back from the data memory
    logic  memToReg;
    logic  regWrite;
    logic  memWrite;
    // beq
    logic  branch;
    // j or jal
    logic  jump;
    // jal only, forces r31 and pc+4
    logic  link;
    aluOpT aluOp;
  } ctrlT;

endpackage

//--- logic/controlUnit.sv
/*
  controlUnit
  main decoder: opcode and funct into the control bundle,
  ALU operation included
*/
module controlUnit import mipsPkg::*; (
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  output ctrlT       ctrl
);

  always_comb begin
    // safe default: no state change
    ctrl       = '0;
    ctrl.aluOp = aluNone;

    case (opcode)
      opRtype: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        // funct picks the operation
        case (funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          default: begin
            // unsupported R-type, e.g. sll from a zero word
            ctrl.aluOp    = aluNone;
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      opLw: begin
        // base plus offset
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        // equal operands give a zero difference
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode, leave the defaults
        ctrl.aluOp = aluNone;
      end
    endcase
  end

endmodule

//--- logic/regFile.sv
/*
  regFile
  32 x 32 register file, two combinational reads,
  one write per clock, r0 reads as zero
*/
module regFile import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    writeEn,
  input  logic [regAddrWidth-1:0] readAddrA,
  input  logic [regAddrWidth-1:0] readAddrB,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic [dataWidth-1:0]    writeData,
  output logic [dataWidth-1:0]    readDataA,
  output logic [dataWidth-1:0]    readDataB
);

  localparam int numRegs = 2 ** regAddrWidth;

  logic [dataWidth-1:0] regs [numRegs];

  // ========================================
  // write port
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes to r0 are dropped
      regs[writeAddr] <= writeData;
    end
  end

  // ========================================
  // read ports
  // ========================================
  // new data shows one edge after writeEn
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

//--- logic/alu.sv
/*
  alu
  32-bit add, sub, and, or and signed set-less-than,
  with a zero flag for beq
*/
module alu import mipsPkg::*; (
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  input  aluOpT                op,
  output logic [dataWidth-1:0] result,
  output logic                 zero
);

  // signed views for slt
  logic signed [dataWidth-1:0] opASigned;
  logic signed [dataWidth-1:0] opBSigned;

  assign opASigned = opA;
  assign opBSigned = opB;

  always_comb begin
    case (op)
      aluAdd: result = opA + opB;
      aluSub: result = opA - opB;
      aluAnd: result = opA & opB;
      aluOr:  result = opA | opB;
      aluSlt: begin
        // 1 when A is below B, two's complement
        result = (opASigned < opBSigned) ? dataWidth'(1) : '0;
      end
      default: begin
        // aluNone and anything unknown
        result = '0;
      end
    endcase
  end

  // pcUnit qualifies this with branch
  assign zero = (result == '0);

endmodule

//--- logic/pcUnit.sv
/*
  pcUnit
  program counter and next-address select
  for sequential, beq and j/jal flow
*/
module pcUnit import mipsPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrlT                 ctrl,
  input  logic                 aluZero,
  input  logic [dataWidth-1:0] immExt,
  input  logic [25:0]          jumpTarget,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] pcPlus4
);

  logic [dataWidth-1:0] pcReg;
  logic [dataWidth-1:0] pcNext;
  logic [dataWidth-1:0] branchAddr;
  logic [dataWidth-1:0] jumpAddr;
  logic                 takeBranch;

  // ========================================
  // candidate addresses
  // ========================================
  assign pcPlus4 = pcReg + dataWidth'(4);

  // word offset, shifted to bytes
  assign branchAddr = pcPlus4 + {immExt[dataWidth-3:0], 2'b00};

  // pseudo-direct: top nibble of pc+4 kept
  assign jumpAddr = {pcPlus4[dataWidth-1 -: 4], jumpTarget, 2'b00};

  // beq taken only on equal operands
  assign takeBranch = ctrl.branch & aluZero;

  always_comb begin
    if (ctrl.jump) begin
      pcNext = jumpAddr;
    end else if (takeBranch) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ========================================
  // pc register
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pc = pcReg;

endmodule

//--- logic/singleCycleMips.sv
/*
  singleCycleMips
  single-cycle core for add, sub, and, or, slt, lw, sw, beq, j, jal;
  instruction memory and data SRAM are external and combinational
*/
module singleCycleMips import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  // instruction fetch
  input  logic [dataWidth-1:0]    instr,
  output logic [dataWidth-1:0]    instrAddr,
  // data SRAM
  input  logic [dataWidth-1:0]    loadData,
  output logic [memAddrWidth-1:0] dataAddr,
  output logic [dataWidth-1:0]    storeData,
  output logic                    memWrite,
  // register write port, visible for checking
  output logic [dataWidth-1:0]    rfWriteData,
  output logic                    rfWrite
);

  // ========================================
  // instruction fields
  // ========================================
  logic [5:0]              opcode;
  logic [5:0]              funct;
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] rd;
  logic [15:0]             imm;
  logic [25:0]             jumpTarget;

  assign opcode     = instr[31:26];
  assign rs         = instr[25:21];
  assign rt         = instr[20:16];
  assign rd         = instr[15:11];
  assign imm        = instr[15:0];
  assign funct      = instr[5:0];
  assign jumpTarget = instr[25:0];

  ctrlT                    ctrl;
  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    rsData;
  logic [dataWidth-1:0]    rtData;
  logic [dataWidth-1:0]    aluOpB;
  logic [dataWidth-1:0]    aluResult;
  logic                    aluZero;
  logic [regAddrWidth-1:0] writeReg;
  logic [dataWidth-1:0]    writeBack;
  logic [dataWidth-1:0]    pc;
  logic [dataWidth-1:0]    pcPlus4;

  // ========================================
  // decode
  // ========================================
  controlUnit u_control (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  // sign extension of the 16-bit immediate
  assign immExt = {{(dataWidth - 16){imm[15]}}, imm};

  // write index: r31 for jal, rd for R-type, rt for lw
  assign writeReg = ctrl.link   ? linkReg :
                    ctrl.regDst ? rd      : rt;

  // ========================================
  // register file and execute
  // ========================================
  regFile u_regs (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (ctrl.regWrite),
    .readAddrA (rs),
    .readAddrB (rt),
    .writeAddr (writeReg),
    .writeData (writeBack),
    .readDataA (rsData),
    .readDataB (rtData)
  );

  // immediate for lw/sw, rt otherwise
  assign aluOpB = ctrl.aluSrc ? immExt : rtData;

  alu u_alu (
    .opA    (rsData),
    .opB    (aluOpB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ========================================
  // next pc
  // ========================================
  pcUnit u_pc (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .aluZero    (aluZero),
    .immExt     (immExt),
    .jumpTarget (jumpTarget),
    .pc         (pc),
    .pcPlus4    (pcPlus4)
  );

  // ========================================
  // write-back and memory interface
  // ========================================
  // return address for jal, load data for lw
  assign writeBack = ctrl.link     ? pcPlus4  :
                     ctrl.memToReg ? loadData : aluResult;

  assign instrAddr = pc;

  // byte address down to a word index
  assign dataAddr    = aluResult[memAddrWidth+1:2];
  assign storeData   = rtData;
  assign memWrite    = ctrl.memWrite;
  assign rfWriteData = writeBack;
  assign rfWrite     = ctrl.regWrite;

endmodule

//--- bench/mipsAsserts.sv
/*
  mipsAsserts
  control checks bound into the single-cycle core
*/
module mipsAsserts import mipsPkg::*; (
  input logic                    clk,
  input logic                    rst,
  input logic [dataWidth-1:0]    instr,
  input logic [dataWidth-1:0]    instrAddr,
  input logic                    memWrite,
  input logic                    rfWrite,
  input logic [regAddrWidth-1:0] writeReg
);

  timeunit 1ns;
  timeprecision 1ps;

  // read by the testbench at the end of the run
  int failCount = 0;

  // a store never writes a register
  noDualWrite: assert property (@(posedge clk) disable iff (!rst)
    !(memWrite && rfWrite))
  else begin
    failCount++;
    $error("memWrite and rfWrite high in the same cycle");
  end

  // pc held at zero while reset is low, sampled mid-cycle
  resetPc: assert property (@(negedge clk) !rst |-> instrAddr == '0)
  else begin
    failCount++;
    $error("instrAddr not zero during reset");
  end

  // jal links into r31
  jalLink: assert property (@(posedge clk) disable iff (!rst)
    (instr[31:26] == opJal) |-> (rfWrite && writeReg == linkReg))
  else begin
    failCount++;
    $error("jal cycle does not write r31");
  end

endmodule

bind singleCycleMips mipsAsserts assertChecks (
  .clk       (clk),
  .rst       (rst),
  .instr     (instr),
  .instrAddr (instrAddr),
  .memWrite  (memWrite),
  .rfWrite   (rfWrite),
  .writeReg  (writeReg)
);

//--- bench/mipsTb.sv
/*
  mipsTb
  testbench for the single-cycle MIPS core with instruction and data
  memory models and a program table checked one instruction per cycle
*/
module mipsTb import mipsPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int resetCycles = 10;
  // 10 reset cycles plus about 25 table entries with margin
  localparam int cycleLimit  = 100;

  // one row of the program table
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        rfWrite;
    logic [31:0] writeData;
    logic        memWrite;
    // dataAddr and storeData only compared for lw and sw
    logic        memCheck;
    logic [6:0]  dataAddr;
    logic [31:0] storeData;
  } stepT;

  logic        clk;
  logic        rst;
  logic [31:0] instr;
  logic [31:0] instrAddr;
  logic [31:0] loadData;
  logic [6:0]  dataAddr;
  logic [31:0] storeData;
  logic        memWrite;
  logic [31:0] rfWriteData;
  logic        rfWrite;

  logic [31:0] imem [64];
  logic [31:0] dmem [128];
  stepT        steps [$];
  int          errorCount;
  int          timeoutCount;
  int          cycleCount;

  singleCycleMips dut (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instrAddr   (instrAddr),
    .loadData    (loadData),
    .dataAddr    (dataAddr),
    .storeData   (storeData),
    .memWrite    (memWrite),
    .rfWriteData (rfWriteData),
    .rfWrite     (rfWrite)
  );

  // ========================================
  // memory models
  // ========================================
  // both reads combinational and word addressed
  assign instr    = imem[instrAddr[7:2]];
  assign loadData = dmem[dataAddr];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[dataAddr] <= storeData;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // instruction encoding
  // ========================================
  function automatic logic [31:0] encodeR(logic [5:0] fn, int rd, int rs, int rt);
    return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
  endfunction

  // lw/sw rt, imm(rs) and beq rs, rt, imm
  function automatic logic [31:0] encodeI(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] encodeJ(logic [5:0] op, int target);
    return {op, 26'(target)};
  endfunction

  task automatic addStep(input logic [31:0] instrWord, input int pc, input bit wr,
                         input int wrData, input bit mw, input bit memChk,
                         input int addr, input int stData);
    stepT s;
    s.instr     = instrWord;
    s.pc        = 32'(pc);
    s.rfWrite   = wr;
    s.writeData = 32'(wrData);
    s.memWrite  = mw;
    s.memCheck  = memChk;
    s.dataAddr  = 7'(addr);
    s.storeData = 32'(stData);
    steps.push_back(s);
  endtask

  // ========================================
  // program table
  // ========================================
  // each row gives instr, pc, rfWrite, writeData, memWrite, memCheck, dataAddr, storeData
  task automatic buildProgram();
    // loads of the preloaded words
    addStep(encodeI(opLw, 0, 1, 0),  0, 1'b1, 7, 1'b0, 1'b1, 0, 0);
    addStep(encodeI(opLw, 0, 2, 4),  4, 1'b1, 5, 1'b0, 1'b1, 1, 0);
    addStep(encodeI(opLw, 0, 3, 8),  8, 1'b1, -3, 1'b0, 1'b1, 2, 0);
    addStep(encodeI(opLw, 0, 4, 12), 12, 1'b1, 'h0F0F, 1'b0, 1'b1, 3, 0);
    // arithmetic on the loaded values
    addStep(encodeR(fnAdd, 5, 1, 2), 16, 1'b1, 12, 1'b0, 1'b0, 0, 0);
    addStep(encodeR(fnSub, 6, 1, 2), 20, 1'b1, 2, 1'b0, 1'b0, 0, 0);
    addStep(encodeR(fnAnd, 7, 4, 3), 24, 1'b1, 'h0F0D, 1'b0, 1'b0, 0, 0);
    addStep(encodeR(fnOr, 8, 6, 2),  28, 1'b1, 7, 1'b0, 1'b0, 0, 0);
    // -3 < 5 and then the reverse
    addStep(encodeR(fnSlt, 9, 3, 2),  32, 1'b1, 1, 1'b0, 1'b0, 0, 0);
    addStep(encodeR(fnSlt, 10, 2, 3), 36, 1'b1, 0, 1'b0, 1'b0, 0, 0);
    // write to r0 is dropped and the read after it sees zero
    addStep(encodeR(fnAdd, 0, 1, 2),  40, 1'b1, 12, 1'b0, 1'b0, 0, 0);
    addStep(encodeR(fnAdd, 11, 0, 0), 44, 1'b1, 0, 1'b0, 1'b0, 0, 0);
    // store r5 to word 4 and read it back
    addStep(encodeI(opSw, 0, 5, 16),  48, 1'b0, 0, 1'b1, 1'b1, 4, 12);
    addStep(encodeI(opLw, 0, 12, 16), 52, 1'b1, 12, 1'b0, 1'b1, 4, 0);
    // 7 != 5 so it falls through to 60
    addStep(encodeI(opBeq, 1, 2, 2),  56, 1'b0, 0, 1'b0, 1'b0, 0, 0);
    // 12 == 12 so 64 + 3*4 = 76
    addStep(encodeI(opBeq, 5, 12, 3), 60, 1'b0, 0, 1'b0, 1'b0, 0, 0);
    // target 25 -> 100 and then jal 40 -> 160 linking 104
    addStep(encodeJ(opJ, 25),   76, 1'b0, 0, 1'b0, 1'b0, 0, 0);
    addStep(encodeJ(opJal, 40), 100, 1'b1, 104, 1'b0, 1'b0, 0, 0);
    addStep(encodeR(fnAdd, 13, 31, 0), 160, 1'b1, 104, 1'b0, 1'b0, 0, 0);
    addStep(encodeR(fnSub, 14, 12, 5), 164, 1'b1, 0, 1'b0, 1'b0, 0, 0);
    addStep(encodeI(opSw, 0, 9, 20),  168, 1'b0, 0, 1'b1, 1'b1, 5, 1);
    addStep(encodeI(opLw, 0, 15, 20), 172, 1'b1, 1, 1'b0, 1'b1, 5, 0);
    // negative offset with 12 - 4 landing on word 2
    addStep(encodeI(opLw, 5, 16, -4), 176, 1'b1, -3, 1'b0, 1'b1, 2, 0);
    addStep(encodeR(fnAnd, 17, 3, 3), 180, 1'b1, -3, 1'b0, 1'b0, 0, 0);
  endtask

  // ========================================
  // checking and end of run
  // ========================================
  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic endRun();
    int assertFails;
    assertFails = dut.assertChecks.failCount;
    $display("errors: %0d, assertion failures: %0d, timeouts: %0d",
             errorCount, assertFails, timeoutCount);
    if (errorCount == 0 && assertFails == 0 && timeoutCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin
    stepT cur;
    rst          = 1'b0;
    errorCount   = 0;
    timeoutCount = 0;
    foreach (imem[i]) imem[i] = '0;
    // unused words carry their own address
    foreach (dmem[i]) dmem[i] = 32'hA500_0000 | 32'(i);
    dmem[0] = 32'd7;
    dmem[1] = 32'd5;
    dmem[2] = -32'sd3;
    dmem[3] = 32'h0000_0F0F;
    buildProgram();
    foreach (steps[i]) imem[steps[i].pc[7:2]] = steps[i].instr;

    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;

    // one instruction per cycle sampled mid-cycle
    foreach (steps[i]) begin
      @(negedge clk);
      cur = steps[i];
      checkValue("instrAddr", instrAddr, cur.pc);
      checkValue("rfWrite", 32'(rfWrite), 32'(cur.rfWrite));
      if (cur.rfWrite) begin
        checkValue("rfWriteData", rfWriteData, cur.writeData);
      end
      checkValue("memWrite", 32'(memWrite), 32'(cur.memWrite));
      if (cur.memCheck) begin
        checkValue("dataAddr", 32'(dataAddr), 32'(cur.dataAddr));
        checkValue("storeData", storeData, cur.storeData);
      end
    end
    endRun();
  end

  // watchdog
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    timeoutCount++;
    $display("timeout: the run did not finish within %0d cycles", cycleLimit);
    endRun();
  end

endmodule

//--- filelist.f
logic/mipsPkg.sv
logic/controlUnit.sv
logic/regFile.sv
logic/alu.sv
logic/pcUnit.sv
logic/singleCycleMips.sv
bench/mipsAsserts.sv
bench/mipsTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the single-cycle MIPS testbench with Verilator
set -e

cd "$(dirname "$0")"

# modules without their own timeunit get 1ns/1ps
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module mipsTb -o mipsSim

# let the testbench reach its summary even after an assertion error
simOut=$(./obj_dir/mipsSim +verilator+error+limit+100 2>&1) || true
echo "$simOut"

if grep -qx "Simulation passed" <<< "$simOut"; then
  exit 0
else
  echo "run.sh: pass line not found in the simulation output"
  exit 1
fi
